// ==== filelist.f ====
logic/videoPkg.sv
logic/panelPkg.sv
logic/sevenSegDecoder.sv
logic/windowBuffer.sv
logic/overlayMixer.sv
logic/secondsCounter.sv
logic/pressTimer.sv
logic/tvOverlayTop.sv
tests/clockGen.sv
tests/tvOverlayTb.sv

// ==== logic/overlayMixer.sv ====
// Channel thresholds, kernel agreement count and output pixel selection
`timescale 1ns/1ps
`default_nettype none

module overlayMixer (
  input  wire  [videoPkg::chanWidth-1:0]  red,
  input  wire  [videoPkg::chanWidth-1:0]  green,
  input  wire  [videoPkg::chanWidth-1:0]  blue,
  input  wire  [videoPkg::levelWidth-1:0] level,        // Threshold, before scaling
  input  wire  [videoPkg::limitWidth-1:0] matchLimit,   // Hit when agreement is below this
  input  wire  [1:0]                      planeSel,
  input  wire                             passThrough,
  input  wire  [videoPkg::windowBits-1:0] window,       // Registered red plane window
  output logic                            redPlane,
  output logic [videoPkg::chanWidth-1:0]  outRed,
  output logic [videoPkg::chanWidth-1:0]  outGreen,
  output logic [videoPkg::chanWidth-1:0]  outBlue
);

  logic [videoPkg::chanWidth-1:0]  threshold;   // Level scaled to channel range
  logic                            greenPlane;
  logic                            bluePlane;
  logic [videoPkg::chanWidth-1:0]  redFull;     // Plane bits at full scale
  logic [videoPkg::chanWidth-1:0]  greenFull;
  logic [videoPkg::chanWidth-1:0]  blueFull;
  logic [videoPkg::windowBits-1:0] agree;       // 1 where window matches kernel
  logic [videoPkg::countWidth-1:0] agreeCount;
  logic                            hit;

  // ------------------------------
  // Threshold planes
  // ------------------------------
  assign threshold  = {level, {videoPkg::levelShift{1'b0}}};
  assign redPlane   = (red > threshold);    // Strictly above the level
  assign greenPlane = (green > threshold);
  assign bluePlane  = (blue > threshold);

  assign redFull   = {videoPkg::chanWidth{redPlane}};
  assign greenFull = {videoPkg::chanWidth{greenPlane}};
  assign blueFull  = {videoPkg::chanWidth{bluePlane}};

  // ------------------------------
  // Kernel agreement
  // ------------------------------
  assign agree = window ~^ videoPkg::shapeKernel;

  always_comb
  begin
    agreeCount = '0;
    for (int i = 0; i < videoPkg::windowBits; i++)
    begin
      agreeCount = agreeCount + agree[i];  // Popcount, fits in 7 bits
    end
  end

  // Few agreeing positions means the shape is there
  assign hit = (agreeCount < {1'b0, matchLimit});

  // ------------------------------
  // Output pixel
  // ------------------------------
  always_comb
  begin
    if (hit)
    begin
      outRed   = '1;  // Pure red marker
      outGreen = '0;
      outBlue  = '0;
    end
    else if (passThrough)
    begin
      outRed   = red;
      outGreen = green;
      outBlue  = blue;
    end
    else
    begin
      case (planeSel)
        2'd0:    {outRed, outGreen, outBlue} = {redFull, redFull, redFull};
        2'd1:    {outRed, outGreen, outBlue} = {greenFull, greenFull, greenFull};
        2'd2:    {outRed, outGreen, outBlue} = {blueFull, blueFull, blueFull};
        default: {outRed, outGreen, outBlue} = {redFull, greenFull, blueFull};  // Own planes
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/panelPkg.sv ====
// Front panel constants: seven-segment codes, digit sizes and default timing counts
`default_nettype none

package panelPkg;

  // ------------------------------
  // Display geometry
  // ------------------------------
  localparam int digitWidth = 4;  // One BCD digit
  localparam int segWidth   = 7;  // Segments g..a
  localparam int digitCount = 4;  // Counted digits, rest are blank

  // Active-low segment patterns for 0..9
  localparam logic [segWidth-1:0] segCodes [10] = '{
    7'b1000000,  // 0
    7'b1111001,  // 1
    7'b0100100,  // 2
    7'b0110000,  // 3
    7'b0011001,  // 4
    7'b0010010,  // 5
    7'b0000010,  // 6
    7'b1111000,  // 7
    7'b0000000,  // 8
    7'b0010000   // 9
  };

  localparam logic [segWidth-1:0] segBlank = 7'b1111111;  // All segments off

  // ------------------------------
  // Default timing on a 50 MHz clock
  // ------------------------------
  localparam int defaultTicksPerSecond = 50_000_000;
  localparam int defaultPressStart     = 21_999_999;  // Button A goes down here
  localparam int defaultPressEnd       = 28_999_999;  // Released and restarted here

endpackage

`default_nettype wire

// ==== logic/pressTimer.sv ====
// Periodic A-button press generator and start-release line for the game controller
`timescale 1ns/1ps
`default_nettype none

module pressTimer #(
  parameter int pressStart = panelPkg::defaultPressStart,  // Press begins after this count
  parameter int pressEnd   = panelPkg::defaultPressEnd     // Release and wrap after this count
) (
  input  wire  OSC_50,
  input  wire  KEY,          // Async reset, active low
  input  wire  start,        // Start switch
  output logic buttonA,
  output logic releaseLine   // Drives B and Right
);

  localparam int pressWidth = $clog2(pressEnd + 1);

  logic [pressWidth-1:0] pressCount;

  // ------------------------------
  // Press counter and button A
  // ------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      pressCount <= '0;
      buttonA    <= 1'b0;
    end
    else if (pressCount == pressStart)
    begin
      buttonA    <= 1'b1;  // Press down
      pressCount <= pressCount + 1'b1;
    end
    else if (pressCount == pressEnd)
    begin
      buttonA    <= 1'b0;  // Let go, start next period
      pressCount <= '0;
    end
    else
    begin
      pressCount <= pressCount + 1'b1;
    end
  end

  // Held released while start is low
  assign releaseLine = !start;

  pressCountRange: assert property (
    @(posedge OSC_50) disable iff (!KEY)
    pressCount <= pressEnd
  ) else $error("pressTimer: counter ran past pressEnd");

endmodule

`default_nettype wire

// ==== logic/secondsCounter.sv ====
// Prescaled four-digit decimal seconds counter with segment outputs
`timescale 1ns/1ps
`default_nettype none

module secondsCounter #(
  parameter int ticksPerSecond = panelPkg::defaultTicksPerSecond  // Clock cycles per count
) (
  input  wire                           OSC_50,
  input  wire                           KEY,   // Async reset, active low
  output logic [panelPkg::segWidth-1:0] hex0,  // Ones
  output logic [panelPkg::segWidth-1:0] hex1,  // Tens
  output logic [panelPkg::segWidth-1:0] hex2,  // Hundreds
  output logic [panelPkg::segWidth-1:0] hex3   // Thousands
);

  localparam int prescaleWidth = $clog2(ticksPerSecond + 1);

  logic [prescaleWidth-1:0]        prescale;
  logic                            secondTick;                      // Prescaler wrap
  logic [panelPkg::digitWidth-1:0] digits [panelPkg::digitCount];  // Index 0 is ones
  logic                            carry  [panelPkg::digitCount];  // Increment request per digit
  logic [panelPkg::segWidth-1:0]   segs   [panelPkg::digitCount];

  // ------------------------------
  // Prescaler
  // ------------------------------
  assign secondTick = (prescale == ticksPerSecond - 1);

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      prescale <= '0;
    end
    else if (secondTick)
    begin
      prescale <= '0;
    end
    else
    begin
      prescale <= prescale + 1'b1;
    end
  end

  // ------------------------------
  // Decimal digits
  // ------------------------------
  always_comb
  begin
    carry[0] = secondTick;
    for (int i = 1; i < panelPkg::digitCount; i++)
    begin
      carry[i] = carry[i-1] && (digits[i-1] == 4'd9);  // Ripple on 9
    end
  end

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      for (int i = 0; i < panelPkg::digitCount; i++)
      begin
        digits[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < panelPkg::digitCount; i++)
      begin
        if (carry[i])
        begin
          // 9 rolls straight to 0, 9999 wraps to 0000
          digits[i] <= (digits[i] == 4'd9) ? '0 : digits[i] + 1'b1;
        end
      end
    end
  end

  // One decoder per digit
  for (genvar d = 0; d < panelPkg::digitCount; d++)
  begin : digitDec
    sevenSegDecoder u_sevenSegDecoder (
      .digit    (digits[d]),
      .segments (segs[d])
    );

    digitRange: assert property (
      @(posedge OSC_50) disable iff (!KEY)
      digits[d] <= 4'd9
    ) else $error("secondsCounter: digit %0d left decimal range", d);
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];

endmodule

`default_nettype wire

// ==== logic/sevenSegDecoder.sv ====
// Decimal digit to active-low seven-segment pattern
`timescale 1ns/1ps
`default_nettype none

module sevenSegDecoder (
  input  wire  [panelPkg::digitWidth-1:0] digit,
  output logic [panelPkg::segWidth-1:0]   segments  // Active low, bit 0 is segment a
);

  // ------------------------------
  // Code lookup
  // ------------------------------
  always_comb
  begin
    if (digit <= 4'd9)
    begin
      segments = panelPkg::segCodes[digit];
    end
    else
    begin
      segments = panelPkg::segBlank;  // Not a decimal digit, show nothing
    end
  end

endmodule

`default_nettype wire

// ==== logic/tvOverlayTop.sv ====
// Board top level: video shape overlay, seconds display and controller press timer
`timescale 1ns/1ps
`default_nettype none

module tvOverlayTop #(
  parameter int lineWidth      = 640,
  parameter int ticksPerSecond = panelPkg::defaultTicksPerSecond,
  parameter int pressStart     = panelPkg::defaultPressStart,
  parameter int pressEnd       = panelPkg::defaultPressEnd
) (
  input  wire                             OSC_50,
  input  wire                             KEY,         // Async reset, active low
  input  wire  [videoPkg::switchWidth-1:0] switches,
  input  wire  [videoPkg::chanWidth-1:0]  red,
  input  wire  [videoPkg::chanWidth-1:0]  green,
  input  wire  [videoPkg::chanWidth-1:0]  blue,
  input  wire                             pixelShift,  // One strobe per pixel
  output logic [videoPkg::chanWidth-1:0]  outRed,
  output logic [videoPkg::chanWidth-1:0]  outGreen,
  output logic [videoPkg::chanWidth-1:0]  outBlue,
  output logic [panelPkg::segWidth-1:0]   hex0,
  output logic [panelPkg::segWidth-1:0]   hex1,
  output logic [panelPkg::segWidth-1:0]   hex2,
  output logic [panelPkg::segWidth-1:0]   hex3,
  output logic [panelPkg::segWidth-1:0]   hex4,
  output logic [panelPkg::segWidth-1:0]   hex5,
  output logic [panelPkg::segWidth-1:0]   hex6,
  output logic [panelPkg::segWidth-1:0]   hex7,
  output logic                            buttonA,
  output logic                            releaseLine
);

  logic [videoPkg::levelWidth-1:0] level;
  logic [videoPkg::limitWidth-1:0] matchLimit;
  logic [1:0]                      planeSel;
  logic                            passThrough;
  logic                            redPlane;     // Mixer to window
  logic [videoPkg::windowBits-1:0] window;       // Window back to mixer

  // ------------------------------
  // Switch fields
  // ------------------------------
  assign level       = switches[videoPkg::levelLsb +: videoPkg::levelWidth];
  assign matchLimit  = switches[videoPkg::limitLsb +: videoPkg::limitWidth];
  assign planeSel    = switches[videoPkg::planeLsb +: 2];
  assign passThrough = switches[videoPkg::passBit];

  // ------------------------------
  // Overlay path
  // ------------------------------
  overlayMixer u_overlayMixer (
    .red         (red),
    .green       (green),
    .blue        (blue),
    .level       (level),
    .matchLimit  (matchLimit),
    .planeSel    (planeSel),
    .passThrough (passThrough),
    .window      (window),
    .redPlane    (redPlane),
    .outRed      (outRed),
    .outGreen    (outGreen),
    .outBlue     (outBlue)
  );

  windowBuffer #(.lineWidth(lineWidth)) u_windowBuffer (
    .OSC_50  (OSC_50),
    .KEY     (KEY),
    .shiftEn (pixelShift),
    .shiftIn (redPlane),
    .window  (window)
  );

  // Panel and controller
  secondsCounter #(.ticksPerSecond(ticksPerSecond)) u_secondsCounter (
    .OSC_50 (OSC_50),
    .KEY    (KEY),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3)
  );

  assign hex4 = panelPkg::segBlank;  // Upper digits unused
  assign hex5 = panelPkg::segBlank;
  assign hex6 = panelPkg::segBlank;
  assign hex7 = panelPkg::segBlank;

  pressTimer #(.pressStart(pressStart), .pressEnd(pressEnd)) u_pressTimer (
    .OSC_50      (OSC_50),
    .KEY         (KEY),
    .start       (switches[videoPkg::startBit]),
    .buttonA     (buttonA),
    .releaseLine (releaseLine)
  );

endmodule

`default_nettype wire

// ==== logic/videoPkg.sv ====
// Video overlay constants for pixel widths, match window geometry and switch fields
`default_nettype none

package videoPkg;

  // ------------------------------
  // Pixel and window geometry
  // ------------------------------
  localparam int chanWidth  = 10;                     // Bits per colour channel
  localparam int windowSide = 11;                     // Match window is square
  localparam int windowBits = windowSide * windowSide;
  localparam int countWidth = 7;                      // Holds 0..121

  // Shape to look for as 11-bit rows with the top row first
  // Bit 0 is the newest pixel in the window
  localparam logic [windowBits-1:0] shapeKernel = {
    11'b00000000000,
    11'b00000000000,
    11'b00110000110,
    11'b00110000110,
    11'b11110000111,
    11'b11110000111,
    11'b11111111111,
    11'b11111111111,
    11'b11111111111,
    11'b11111111111,
    11'b11111111111
  };

  // ------------------------------
  // Switch word fields
  // ------------------------------
  localparam int switchWidth = 18;
  localparam int levelLsb    = 13;  // Threshold level in bits 17..13
  localparam int levelWidth  = 5;
  localparam int levelShift  = 5;   // Level scaled up to channel range
  localparam int limitLsb    = 7;   // Match limit in bits 12..7
  localparam int limitWidth  = 6;
  localparam int planeLsb    = 3;   // 2-bit plane select
  localparam int passBit     = 2;   // Raw pixel passthrough
  localparam int startBit    = 0;   // Controller start

endpackage

`default_nettype wire

// ==== logic/windowBuffer.sv ====
// Binary line history for the red plane, tapped as an 11x11 sliding window
`timescale 1ns/1ps
`default_nettype none

module windowBuffer #(
  parameter int lineWidth = 640                    // Pixels per video line
) (
  input  wire                                 OSC_50,
  input  wire                                 KEY,      // Async reset, active low
  input  wire                                 shiftEn,  // Pixel strobe
  input  wire                                 shiftIn,  // New plane bit
  output logic [videoPkg::windowBits-1:0]     window
);

  // Ten full lines plus one window row of pixels
  localparam int historyLen = (videoPkg::windowSide - 1) * lineWidth + videoPkg::windowSide;

  logic [historyLen-1:0] history;  // Bit 0 is the newest pixel

  // ------------------------------
  // History shift register
  // ------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      history <= '0;  // Window starts all dark
    end
    else if (shiftEn)
    begin
      history <= {history[historyLen-2:0], shiftIn};
    end
  end

  // ------------------------------
  // Window taps
  // ------------------------------
  // Row r sits r lines back, column c sits c pixels back
  for (genvar row = 0; row < videoPkg::windowSide; row++)
  begin : rowTap
    for (genvar col = 0; col < videoPkg::windowSide; col++)
    begin : colTap
      assign window[row * videoPkg::windowSide + col] = history[row * lineWidth + col];
    end
  end

  // Threshold plane from the mixer must be settled whenever it is taken
  shiftInKnown: assert property (
    @(posedge OSC_50) disable iff (!KEY)
    shiftEn |-> !$isunknown(shiftIn)
  ) else $error("windowBuffer: unknown plane bit shifted in");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the overlay testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tvOverlayTb -f filelist.f -o simTb

# Failure is judged from the log, not the simulator exit code
./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== tests/clockGen.sv ====
// Testbench clock and power-on reset source for the board top level
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int periodNs    = 100,  // Clock period
  parameter int resetCycles = 3     // Rising edges with reset held
) (
  output logic OSC_50,
  output logic KEY     // Active low
);

  // ------------------------------
  // Free-running clock
  // ------------------------------
  initial
  begin
    OSC_50 = 1'b0;
    forever #(periodNs / 2) OSC_50 = ~OSC_50;
  end

  // Reset released on a falling edge, clear of the active edge
  initial
  begin
    KEY = 1'b0;
    repeat (resetCycles) @(posedge OSC_50);
    @(negedge OSC_50);
    KEY = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tvOverlayTb.sv ====
// Testbench for the overlay top level with random and shaped pixels, panel and press timing
`timescale 1ns/1ps
`default_nettype none

module tvOverlayTb;

  localparam int lineWidth      = 16;  // Short lines keep the history small
  localparam int ticksPerSecond = 5;
  localparam int pressStart     = 3;
  localparam int pressEnd       = 7;

  localparam int chanW   = videoPkg::chanWidth;
  localparam int side    = videoPkg::windowSide;
  localparam int histLen = (side - 1) * lineWidth + side;  // Ten lines plus one row

  // ------------------------------
  // Test lengths and cycle limit
  // ------------------------------
  localparam int resetLen     = 8;
  localparam int passLen      = 120;
  localparam int planeReps    = 12;                         // Per plane and level
  localparam int planeLen     = 4 * 4 * planeReps;
  localparam int kernelLen    = 2 * (2 * histLen + 6);      // Two shaped runs with gaps
  localparam int randLen      = 400;
  localparam int budget       = resetLen + passLen + planeLen + kernelLen + randLen + 4;
  localparam int timeoutLimit = budget + budget / 4;

  wire                              OSC_50;
  wire                              KEY;
  logic [videoPkg::switchWidth-1:0] switches;
  logic [chanW-1:0]                 red;
  logic [chanW-1:0]                 green;
  logic [chanW-1:0]                 blue;
  logic                             pixelShift;
  wire  [chanW-1:0]                 outRed;
  wire  [chanW-1:0]                 outGreen;
  wire  [chanW-1:0]                 outBlue;
  wire  [panelPkg::segWidth-1:0]    hex0;
  wire  [panelPkg::segWidth-1:0]    hex1;
  wire  [panelPkg::segWidth-1:0]    hex2;
  wire  [panelPkg::segWidth-1:0]    hex3;
  wire  [panelPkg::segWidth-1:0]    hex4;
  wire  [panelPkg::segWidth-1:0]    hex5;
  wire  [panelPkg::segWidth-1:0]    hex6;
  wire  [panelPkg::segWidth-1:0]    hex7;
  wire                              buttonA;
  wire                              releaseLine;

  logic [31:0]        lfsrState;
  logic [histLen-1:0] modelHist;   // Expected plane history with bit 0 newest
  int                 edgeCount;   // Rising edges since reset release
  int                 cycleCount;
  int                 secs;
  string              testName;

  clockGen #(.periodNs(100), .resetCycles(3)) u_clockGen (
    .OSC_50 (OSC_50),
    .KEY    (KEY)
  );

  tvOverlayTop #(
    .lineWidth      (lineWidth),
    .ticksPerSecond (ticksPerSecond),
    .pressStart     (pressStart),
    .pressEnd       (pressEnd)
  ) u_tvOverlayTop (
    .OSC_50      (OSC_50),
    .KEY         (KEY),
    .switches    (switches),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .pixelShift  (pixelShift),
    .outRed      (outRed),
    .outGreen    (outGreen),
    .outBlue     (outBlue),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5),
    .hex6        (hex6),
    .hex7        (hex7),
    .buttonA     (buttonA),
    .releaseLine (releaseLine)
  );

  // ------------------------------
  // Random bits
  // ------------------------------
  function automatic logic nextBit();
    lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
    return lfsrState[0];  // Taps 32 22 2 1
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[30:0], nextBit()};
    end
    return bits;
  endfunction

  function automatic logic [videoPkg::switchWidth-1:0] packSwitches(input logic [4:0] lvl,
      input logic [5:0] lim, input logic [1:0] plane, input logic pass, input logic st);
    logic [videoPkg::switchWidth-1:0] sw;
    sw = '0;
    sw[videoPkg::levelLsb +: videoPkg::levelWidth] = lvl;
    sw[videoPkg::limitLsb +: videoPkg::limitWidth] = lim;
    sw[videoPkg::planeLsb +: 2]                    = plane;
    sw[videoPkg::passBit]                          = pass;
    sw[videoPkg::startBit]                         = st;
    return sw;
  endfunction

  // Red value on the wanted side of the level-16 threshold (512)
  function automatic logic [chanW-1:0] redForPlane(input logic planeOn);
    logic [chanW-1:0] offset;
    offset = takeBits(planeOn ? 8 : 9);
    return planeOn ? (10'd1023 - offset) : offset;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic planeBit(input logic [chanW-1:0] chan,
      input logic [videoPkg::switchWidth-1:0] sw);
    logic [chanW-1:0] thr;
    thr = '0;
    thr[chanW-1:videoPkg::levelShift] = sw[videoPkg::levelLsb +: videoPkg::levelWidth];
    return chan > thr;  // Strictly above
  endfunction

  function automatic logic [3*chanW-1:0] expectedPixel(input logic [chanW-1:0] r, g, b,
      input logic [videoPkg::switchWidth-1:0] sw, input logic [histLen-1:0] hist);
    int               agreeCnt;
    logic [chanW-1:0] rF;
    logic [chanW-1:0] gF;
    logic [chanW-1:0] bF;
    agreeCnt = 0;
    for (int row = 0; row < side; row++)
    begin
      for (int col = 0; col < side; col++)
      begin
        if (hist[row * lineWidth + col] == videoPkg::shapeKernel[row * side + col])
          agreeCnt++;
      end
    end
    rF = planeBit(r, sw) ? 10'h3ff : 10'h000;  // Full-scale plane views
    gF = planeBit(g, sw) ? 10'h3ff : 10'h000;
    bF = planeBit(b, sw) ? 10'h3ff : 10'h000;
    if (agreeCnt < int'(sw[videoPkg::limitLsb +: videoPkg::limitWidth]))
      return {10'h3ff, 10'h000, 10'h000};
    if (sw[videoPkg::passBit])
      return {r, g, b};
    case (sw[videoPkg::planeLsb +: 2])
      2'd0:    return {rF, rF, rF};
      2'd1:    return {gF, gF, gF};
      2'd2:    return {bF, bF, bF};
      default: return {rF, gF, bF};
    endcase
  endfunction

  // Plane history taken on the same edges as the DUT
  always @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      modelHist <= '0;
    else if (pixelShift)
      modelHist <= {modelHist[histLen-2:0], planeBit(red, switches)};
  end

  always @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      edgeCount <= 0;
    else
      edgeCount <= edgeCount + 1;
  end

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic compareValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("error %s: expected %0h actual %0h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "first mismatch, run stopped");
    end
  endtask

  // All outputs sampled mid-cycle away from input changes
  always @(negedge OSC_50)
  begin
    if (KEY)
    begin
      secs = (edgeCount / ticksPerSecond) % 10000;
      compareValue({testName, " pixel"}, expectedPixel(red, green, blue, switches, modelHist),
                   {outRed, outGreen, outBlue});
      compareValue("seconds hex0", panelPkg::segCodes[secs % 10], hex0);
      compareValue("seconds hex1", panelPkg::segCodes[(secs / 10) % 10], hex1);
      compareValue("seconds hex2", panelPkg::segCodes[(secs / 100) % 10], hex2);
      compareValue("seconds hex3", panelPkg::segCodes[secs / 1000], hex3);
      compareValue("blank hex4..7", {4{panelPkg::segBlank}}, {hex4, hex5, hex6, hex7});
      compareValue("press buttonA", (edgeCount % (pressEnd + 1)) > pressStart, buttonA);
      compareValue("press release", !switches[videoPkg::startBit], releaseLine);
    end
  end

  always @(posedge OSC_50)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > timeoutLimit)
    begin
      $display("timeout: stimulus did not finish within %0d cycles", timeoutLimit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic driveCycle(input logic [chanW-1:0] r, g, b, input logic shift,
      input logic [videoPkg::switchWidth-1:0] sw);
    @(posedge OSC_50);
    red        <= r;
    green      <= g;
    blue       <= b;
    pixelShift <= shift;
    switches   <= sw;
  endtask

  // Loads the whole history so the window holds the kernel or its inverse
  task automatic runKernelSequence(input logic invert, input logic [5:0] limit);
    logic [histLen-1:0]               target;
    logic [videoPkg::switchWidth-1:0] sw;
    int                               idx;
    logic                             shiftNow;
    for (int i = 0; i < histLen; i++)
      target[i] = nextBit();  // Off-window filler
    for (int row = 0; row < side; row++)
      for (int col = 0; col < side; col++)
        target[row * lineWidth + col] = videoPkg::shapeKernel[row * side + col] ^ invert;
    sw  = packSwitches(5'd16, limit, takeBits(2), 1'b0, nextBit());
    idx = histLen - 1;  // Oldest bit goes in first
    while (idx >= 0)
    begin
      shiftNow = (takeBits(2) != 0);  // Gap one cycle in four
      driveCycle(redForPlane(target[idx]), takeBits(10), takeBits(10), shiftNow, sw);
      if (shiftNow)
        idx--;
    end
    repeat (4) driveCycle(redForPlane(nextBit()), takeBits(10), takeBits(10), 1'b0, sw);
  endtask

  initial
  begin : stimulus
    logic [videoPkg::switchWidth-1:0] sw;
    logic                             shiftNow;
    lfsrState  = 32'h40de;
    cycleCount = 0;
    testName   = "reset";
    switches   = '0;
    red        = '0;
    green      = '0;
    blue       = '0;
    pixelShift = 1'b0;
    @(posedge KEY);
    repeat (resetLen) @(posedge OSC_50);

    testName = "passthrough";  // Limit 0 never hits
    for (int i = 0; i < passLen; i++)
    begin
      sw = packSwitches(takeBits(5), 6'd0, takeBits(2), 1'b1, nextBit());
      driveCycle(takeBits(10), takeBits(10), takeBits(10), nextBit(), sw);
    end

    testName = "plane view";
    for (int p = 0; p < 4; p++)
      for (int l = 0; l < 4; l++)
        for (int i = 0; i < planeReps; i++)
        begin
          sw = packSwitches(5'(l * 10), 6'd0, 2'(p), 1'b0, nextBit());
          driveCycle(takeBits(10), takeBits(10), takeBits(10), nextBit(), sw);
        end

    testName = "kernel shape";
    runKernelSequence(1'b0, 6'd60);  // Full agreement so no hit
    runKernelSequence(1'b1, 6'd60);  // No agreement
    @(negedge OSC_50);
    compareValue("kernel inverse hit", {10'h3ff, 20'h0}, {outRed, outGreen, outBlue});

    testName = "kernel random";
    for (int i = 0; i < randLen; i++)
    begin
      sw = packSwitches(5'd16, (i < randLen / 2) ? 6'd60 : 6'd63, takeBits(2), nextBit(),
                        nextBit());
      shiftNow = (takeBits(2) != 0);
      driveCycle(redForPlane(nextBit()), takeBits(10), takeBits(10), shiftNow, sw);
    end

    // Two more checked falling edges, then stop on a rising edge
    testName = "final";
    repeat (2) @(posedge OSC_50);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
